// ==== bench/msu_checker.sv ====
`timescale 1ns/1ns
`include "msu_cfg.svh"

module msu_checker
   import msu_pkg::*;
(
   input  logic      clk,
   input  logic      reset_1d,
   input  logic      s_axis_tvalid,
   input  logic      s_axis_tready,
   input  logic      s_axis_tlast,
   input  logic      m_axis_tvalid,
   input  logic      m_axis_tready,
   input  axi_word_t m_axis_tdata,
   input  logic      m_axis_tlast,
   input  logic      start_xfer,
   input  logic      ap_done,
   output int        jobs_done,
   output int        jobs_failed,
   output int        error_count
);

   localparam int OUT_WORDS = `MSU_OUT_WORDS;

   // Expected values per job in file order
   string       name_q[$];
   iter_count_t count_q[$];
   residue_t    result_q[$];

   axi_word_t words[OUT_WORDS];
   int        word_cnt;
   int        job_errors;
   int        load_errors;
   int        check_errors;
   logic      xfer_seen;
   logic      job_running;
   logic      stalled;
   axi_word_t stalled_data;

   assign error_count = load_errors + check_errors;

   task automatic load_expected();
      int              fd;
      int              n;
      string           line;
      logic [8*32-1:0] name_bits;
      iter_count_t     t_start;
      iter_count_t     t_final;
      residue_t        x;
      iter_count_t     exp_count;
      residue_t        exp_result;
      fd = $fopen("bench/msu_input.txt", "r");
      if (fd == 0) begin
         $display("Checker cannot open bench/msu_input.txt");
         load_errors++;
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
               n = $sscanf(line, "%s %h %h %h %h %h", name_bits, t_start, t_final, x,
                           exp_count, exp_result);
               if (n == 6) begin
                  name_q.push_back(string'(name_bits));
                  count_q.push_back(exp_count);
                  result_q.push_back(exp_result);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic flag_error(input string msg);
      $display("%s", msg);
      job_errors++;
      check_errors++;
   endtask

   task automatic take_word(input string name);
      if (!xfer_seen) begin
         flag_error($sformatf("%s: output word taken before start_xfer", name));
      end
      if (word_cnt >= OUT_WORDS) begin
         flag_error($sformatf("%s: more than %0d output words taken", name, OUT_WORDS));
      end else begin
         if (m_axis_tlast !== (word_cnt == OUT_WORDS - 1)) begin
            flag_error($sformatf("CHECK FAILED %s m_axis_tlast on word %0d: expected %0b, actual %0b",
                                 name, word_cnt, word_cnt == OUT_WORDS - 1, m_axis_tlast));
         end
         words[word_cnt] = m_axis_tdata;
         word_cnt++;
      end
   endtask

   task automatic finish_job(input string name);
      iter_count_t count_got;
      residue_t    result_got;
      count_got  = {words[1], words[0]};
      result_got = {words[3], words[2]};
      if (word_cnt != OUT_WORDS) begin
         flag_error($sformatf("%s: ap_done after %0d output words", name, word_cnt));
      end
      if (!xfer_seen) begin
         flag_error($sformatf("%s: ap_done without a start_xfer pulse", name));
      end
      if (jobs_done >= name_q.size()) begin
         flag_error("ap_done for a job that the input file does not hold");
      end else begin
         if (count_got !== count_q[jobs_done]) begin
            flag_error($sformatf("CHECK FAILED %s final count: expected %h, actual %h",
                                 name, count_q[jobs_done], count_got));
         end
         if (result_got !== result_q[jobs_done]) begin
            flag_error($sformatf("CHECK FAILED %s result: expected %h, actual %h",
                                 name, result_q[jobs_done], result_got));
         end
      end
      if (job_errors == 0) begin
         $display("Job %s: ok, count %h, result %h", name, count_got, result_got);
      end else begin
         $display("Job %s: failed with %0d errors", name, job_errors);
         jobs_failed++;
      end
      jobs_done++;
      word_cnt    = 0;
      job_errors  = 0;
      xfer_seen   = 1'b0;
      job_running = 1'b0;
   endtask

   initial begin
      load_expected();
   end

   //////////////////////////////
   // Monitor
   //////////////////////////////

   always @(posedge clk) begin
      string name;
      name = (jobs_done < name_q.size()) ? name_q[jobs_done] : "unknown";
      if (reset_1d) begin
         jobs_done    = 0;
         jobs_failed  = 0;
         check_errors = 0;
         word_cnt     = 0;
         job_errors   = 0;
         xfer_seen    = 1'b0;
         job_running  = 1'b0;
         stalled      = 1'b0;
      end else begin
         // No new frame until the running job is done
         if (job_running && s_axis_tready) begin
            flag_error($sformatf("%s: s_axis_tready high while the job runs", name));
         end
         if (s_axis_tvalid && s_axis_tready && s_axis_tlast) begin
            job_running = 1'b1;
         end
         if (stalled && m_axis_tvalid && m_axis_tdata !== stalled_data) begin
            flag_error($sformatf("%s: m_axis_tdata changed during a stall", name));
         end
         stalled      = m_axis_tvalid && !m_axis_tready;
         stalled_data = m_axis_tdata;
         if (start_xfer) begin
            if (xfer_seen || word_cnt != 0) begin
               flag_error($sformatf("%s: start_xfer pulsed out of place", name));
            end
            xfer_seen = 1'b1;
         end
         if (m_axis_tvalid && m_axis_tready) begin
            take_word(name);
         end
         if (ap_done) begin
            finish_job(name);
         end
      end
   end

endmodule

// ==== bench/msu_input.txt ====
# name t_start t_final x expected_count expected_result, values in hex
# expected_result is x squared (t_final - t_start) times modulo 7fffffffffffffe7
one_sq_small 0 1 3 1 9
one_sq_wrap a b 4000000000000000 b 2000000000000096
one_sq_shift32 0 1 100000000 1 32
neg_one_single 5 6 7fffffffffffffe6 6 1
five_sq_hi_count 1fffffffe 200000003 3 200000003 6954fe21e3e81
neg_two_nine 20 29 7fffffffffffffe5 29 2386f26fc100
neg_one_hundred 0 64 7fffffffffffffe6 64 1
zero_three 7 a 0 a 0
two_eight 100 108 2 108 5f5e10

// ==== bench/msu_tb.sv ====
`timescale 1ns/1ns
`include "msu_cfg.svh"

module msu_tb
   import msu_pkg::*;
();

   localparam int CLK_PERIOD        = 4;
   localparam int RESET_CYCLES      = 16;
   localparam int IN_WORDS          = `MSU_IN_WORDS;
   localparam int CYCLES_PER_SQUARE = 65;
   localparam int SLACK_CYCLES      = 200;

   logic      clk = 1'b0;
   logic      reset_1d;
   logic      ap_start;
   logic      s_axis_tvalid;
   logic      s_axis_tready;
   axi_word_t s_axis_tdata;
   logic      s_axis_tlast;
   logic      m_axis_tvalid;
   logic      m_axis_tready;
   axi_word_t m_axis_tdata;
   logic      m_axis_tlast;
   logic      start_xfer;
   logic      ap_done;

   int jobs_done;
   int jobs_failed;
   int check_errors;
   int tb_errors = 0;
   int seed = 32'he35a;
   int ready_draw;
   bit jobs_loaded = 1'b0;

   // Job stimulus from the data file
   iter_count_t t_start_q[$];
   iter_count_t t_final_q[$];
   residue_t    x_q[$];

   always #(CLK_PERIOD / 2) clk = ~clk;

   msu_top i_msu_top (
      .clk           (clk),
      .reset_1d      (reset_1d),
      .ap_start      (ap_start),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tlast  (s_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tlast  (m_axis_tlast),
      .start_xfer    (start_xfer),
      .ap_done       (ap_done)
   );

   msu_checker i_msu_checker (
      .clk           (clk),
      .reset_1d      (reset_1d),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .s_axis_tlast  (s_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tlast  (m_axis_tlast),
      .start_xfer    (start_xfer),
      .ap_done       (ap_done),
      .jobs_done     (jobs_done),
      .jobs_failed   (jobs_failed),
      .error_count   (check_errors)
   );

   task automatic load_jobs();
      int              fd;
      int              n;
      string           line;
      logic [8*32-1:0] name_bits;
      iter_count_t     t_start;
      iter_count_t     t_final;
      residue_t        x;
      iter_count_t     exp_count;
      residue_t        exp_result;
      fd = $fopen("bench/msu_input.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
               n = $sscanf(line, "%s %h %h %h %h %h", name_bits, t_start, t_final, x,
                           exp_count, exp_result);
               if (n == 6) begin
                  t_start_q.push_back(t_start);
                  t_final_q.push_back(t_final);
                  x_q.push_back(x);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // Six words go out lowest first with random idle gaps and wait for tready
   task automatic send_frame(input int k);
      logic [IN_WORDS*`MSU_AXI_LEN-1:0] frame;
      int                               gap;
      frame = {x_q[k], t_final_q[k], t_start_q[k]};
      for (int i = 0; i < IN_WORDS; i++) begin
         gap = $unsigned($random(seed)) % 4;
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         s_axis_tvalid = 1'b1;
         s_axis_tdata  = frame[i*`MSU_AXI_LEN +: `MSU_AXI_LEN];
         s_axis_tlast  = (i == IN_WORDS - 1);
         @(posedge clk);
         while (!s_axis_tready) begin
            @(posedge clk);
         end
         #1;
         ap_start      = 1'b0;
         s_axis_tvalid = 1'b0;
         s_axis_tlast  = 1'b0;
      end
   endtask

   // Random back-pressure on the output stream, drawn on the edge itself
   always @(posedge clk) begin
      ready_draw = $random(seed);
      #1;
      m_axis_tready = ready_draw[0];
   end

   initial begin
      reset_1d      = 1'b1;
      ap_start      = 1'b0;
      s_axis_tvalid = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tlast  = 1'b0;
      m_axis_tready = 1'b0;
      load_jobs();
      jobs_loaded = 1'b1;
      if (t_start_q.size() == 0) begin
         $display("No jobs could be read from bench/msu_input.txt");
         tb_errors++;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset_1d = 1'b0;
      for (int k = 0; k < t_start_q.size(); k++) begin
         ap_start = 1'b1;
         send_frame(k);
         wait (jobs_done > k);
         @(posedge clk);
         #1;
      end
      $display("Jobs: %0d in file, %0d finished, %0d failed, %0d errors",
               t_start_q.size(), jobs_done, jobs_failed, check_errors + tb_errors);
      if (tb_errors == 0 && check_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   //////////////////////////////
   // Watchdog
   //////////////////////////////

   initial begin
      longint unsigned limit_cycles;
      wait (jobs_loaded);
      limit_cycles = RESET_CYCLES;
      foreach (t_start_q[k]) begin
         limit_cycles += CYCLES_PER_SQUARE * (t_final_q[k] - t_start_q[k]) + SLACK_CYCLES;
      end
      #(limit_cycles * CLK_PERIOD);
      $display("Timeout: the jobs did not finish within %0d clock cycles", limit_cycles);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f sim.f --top-module msu_tb -o msu_sim \
   && ./obj_dir/msu_sim | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// ==== sim.f ====
+incdir+src
src/msu_pkg.sv
src/modsqr_engine.sv
src/msu.sv
src/msu_top.sv
bench/msu_checker.sv
bench/msu_tb.sv

// ==== src/modsqr_engine.sv ====
`timescale 1ns/1ns
`include "msu_cfg.svh"

module modsqr_engine
   import msu_pkg::*;
(
   input  logic     clk,
   input  logic     reset_1d,
   input  logic     sq_start,
   input  logic     sq_stop,
   input  residue_t sq_in,
   output logic     sq_valid,
   output residue_t sq_out
);

   localparam int IDX_W = $clog2(`MSU_SQ_BITS);
   localparam residue_t MODULUS = `MSU_MODULUS;
   localparam logic [`MSU_SQ_BITS:0] MOD_WIDE = {1'b0, MODULUS};

   // Control
   logic             running;
   logic [IDX_W-1:0] bit_idx;

   // Datapath
   residue_t operand;
   residue_t acc;
   residue_t dbl_red;
   residue_t add_red;
   residue_t acc_next;

   // One conditional subtraction for inputs below twice the modulus
   function automatic residue_t reduce_once(input logic [`MSU_SQ_BITS:0] v);
      logic [`MSU_SQ_BITS:0] diff;
      diff = v - MOD_WIDE;
      if (v >= MOD_WIDE) begin
         return diff[`MSU_SQ_BITS-1:0];
      end
      return v[`MSU_SQ_BITS-1:0];
   endfunction

   //////////////////////////////
   // Bit step
   //////////////////////////////

   // acc becomes 2*acc (+ operand) mod M as the operand is scanned MSB first
   always_comb begin
      dbl_red = reduce_once({acc, 1'b0});
      add_red = reduce_once({1'b0, dbl_red} + {1'b0, operand});
      if (operand[bit_idx]) begin
         acc_next = add_red;
      end else begin
         acc_next = dbl_red;
      end
   end

   //////////////////////////////
   // Sequencing
   //////////////////////////////

   // A load cycle and 64 steps per square with the valid cycle used as the restart
   always_ff @(posedge clk) begin
      if (reset_1d) begin
         running  <= 1'b0;
         sq_valid <= 1'b0;
         bit_idx  <= '0;
      end else if (sq_start) begin
         running  <= 1'b1;
         sq_valid <= 1'b0;
         bit_idx  <= IDX_W'(`MSU_SQ_BITS - 1);
      end else if (sq_stop) begin
         running  <= 1'b0;
         sq_valid <= 1'b0;
      end else if (running) begin
         if (sq_valid) begin
            // Restart on the published square
            sq_valid <= 1'b0;
            bit_idx  <= IDX_W'(`MSU_SQ_BITS - 1);
         end else begin
            sq_valid <= (bit_idx == '0);
            bit_idx  <= bit_idx - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sq_start) begin
         operand <= sq_in;
         acc     <= '0;
      end else if (running && !sq_stop) begin
         if (sq_valid) begin
            // Last result becomes the next operand
            operand <= acc;
            acc     <= '0;
         end else begin
            acc <= acc_next;
         end
      end
   end

   // Accumulator holds the finished square while sq_valid is high
   assign sq_out = acc;

endmodule

// ==== src/msu.sv ====
`timescale 1ns/1ns
`include "msu_cfg.svh"

module msu
   import msu_pkg::*;
(
   input  logic      clk,
   input  logic      reset_1d,

   input  logic      ap_start,
   output logic      start_xfer,
   output logic      ap_done,

   // Input word stream
   input  logic      s_axis_tvalid,
   output logic      s_axis_tready,
   input  axi_word_t s_axis_tdata,
   input  logic      s_axis_tlast,

   // Output word stream
   output logic      m_axis_tvalid,
   input  logic      m_axis_tready,
   output axi_word_t m_axis_tdata,
   output logic      m_axis_tlast,

   // Squaring engine
   output logic      sq_start,
   output logic      sq_stop,
   output residue_t  sq_in,
   input  logic      sq_valid,
   input  residue_t  sq_out
);

   localparam int IN_BITS  = `MSU_IN_WORDS * `MSU_AXI_LEN;
   localparam int OUT_BITS = `MSU_OUT_WORDS * `MSU_AXI_LEN;
   localparam int T_LEN    = `MSU_T_LEN;
   localparam word_index_t LAST_OUT_IDX = word_index_t'(`MSU_OUT_WORDS - 1);

   msu_state_t state;
   msu_state_t next_state;

   // Job fields
   iter_count_t t_current;
   iter_count_t t_final;
   iter_count_t t_next;

   // Frames
   logic [IN_BITS-1:0]  in_frame;
   logic [OUT_BITS-1:0] out_frame;
   word_index_t         out_idx;

   logic in_shift;
   logic out_shift;
   logic final_iteration;

   //////////////////////////////
   // Job FSM
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset_1d) begin
         state <= st_init;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         st_init: begin
            if (ap_start) begin
               next_state = st_recv;
            end
         end
         st_recv: begin
            // Frame ends on the word flagged with tlast
            if (in_shift && s_axis_tlast) begin
               next_state = st_sqin;
            end
         end
         st_sqin: begin
            next_state = st_start;
         end
         st_start: begin
            next_state = st_compute;
         end
         st_compute: begin
            if (final_iteration) begin
               next_state = st_prepare_send;
            end
         end
         st_prepare_send: begin
            next_state = st_send;
         end
         st_send: begin
            if (out_shift && out_idx == LAST_OUT_IDX) begin
               next_state = st_idle;
            end
         end
         st_idle: begin
            next_state = st_init;
         end
         default: begin
            next_state = st_init;
         end
      endcase
   end

   assign start_xfer = (state == st_prepare_send);
   assign ap_done    = (state == st_idle);

   //////////////////////////////
   // Input unpacking
   //////////////////////////////

   assign s_axis_tready = (state == st_recv);
   assign in_shift      = s_axis_tvalid && s_axis_tready;

   // Lowest word enters first and ends up at the bottom
   always_ff @(posedge clk) begin
      if (in_shift) begin
         in_frame <= {s_axis_tdata, in_frame[IN_BITS-1:`MSU_AXI_LEN]};
      end
   end

   //////////////////////////////
   // Iteration counting
   //////////////////////////////

   assign t_next          = t_current + 1'b1;
   assign final_iteration = (state == st_compute) && sq_valid &&
                            (t_next == t_final);

   always_ff @(posedge clk) begin
      if (state == st_sqin) begin
         t_current <= in_frame[T_LEN-1:0];
         t_final   <= in_frame[2*T_LEN-1:T_LEN];
         sq_in     <= in_frame[IN_BITS-1:2*T_LEN];
      end else if (state == st_compute && sq_valid) begin
         t_current <= t_next;
      end
   end

   assign sq_start = (state == st_start);
   // Engine goes idle on the same cycle the last square is taken
   assign sq_stop  = final_iteration;

   //////////////////////////////
   // Output packing
   //////////////////////////////

   assign out_shift = m_axis_tvalid && m_axis_tready;

   always_ff @(posedge clk) begin
      if (final_iteration) begin
         out_frame <= {sq_out, t_next};
      end else if (out_shift) begin
         out_frame <= {{`MSU_AXI_LEN{1'b0}}, out_frame[OUT_BITS-1:`MSU_AXI_LEN]};
      end
   end

   // Counts taken words only, so stalls never skip one
   always_ff @(posedge clk) begin
      if (reset_1d) begin
         out_idx <= '0;
      end else if (final_iteration) begin
         out_idx <= '0;
      end else if (out_shift) begin
         out_idx <= out_idx + 1'b1;
      end
   end

   assign m_axis_tvalid = (state == st_send);
   assign m_axis_tdata  = out_frame[`MSU_AXI_LEN-1:0];
   assign m_axis_tlast  = (state == st_send) && (out_idx == LAST_OUT_IDX);

endmodule

// ==== src/msu_cfg.svh ====
`ifndef MSU_CFG_SVH
`define MSU_CFG_SVH

// Stream word width
`define MSU_AXI_LEN 32

// Iteration counts and residue widths
`define MSU_T_LEN 64
`define MSU_SQ_BITS 64

// Odd modulus kept below 2**63 so twice any residue fits in 65 bits
`define MSU_MODULUS 64'h7fff_ffff_ffff_ffe7

// Input frame carries t_start, t_final and x as low and high words
`define MSU_IN_WORDS 6

// Output frame carries the final count and the result as low and high words
`define MSU_OUT_WORDS 4

`endif

// ==== src/msu_pkg.sv ====
`include "msu_cfg.svh"

package msu_pkg;

   // One word on either stream
   typedef logic [`MSU_AXI_LEN-1:0] axi_word_t;

   // Iteration count
   typedef logic [`MSU_T_LEN-1:0] iter_count_t;

   // Residue modulo the fixed modulus
   typedef logic [`MSU_SQ_BITS-1:0] residue_t;

   // Word position inside an input or output frame
   typedef logic [2:0] word_index_t;

   // Job controller states
   typedef enum logic [2:0] {
      st_init,
      st_recv,
      st_sqin,
      st_start,
      st_compute,
      st_prepare_send,
      st_send,
      st_idle
   } msu_state_t;

endpackage

// ==== src/msu_top.sv ====
`timescale 1ns/1ns

module msu_top
   import msu_pkg::*;
(
   input  logic      clk,
   input  logic      reset_1d,
   input  logic      ap_start,

   input  logic      s_axis_tvalid,
   output logic      s_axis_tready,
   input  axi_word_t s_axis_tdata,
   input  logic      s_axis_tlast,

   output logic      m_axis_tvalid,
   input  logic      m_axis_tready,
   output axi_word_t m_axis_tdata,
   output logic      m_axis_tlast,

   output logic      start_xfer,
   output logic      ap_done
);

   // Controller to engine
   logic     sq_start;
   logic     sq_stop;
   logic     sq_valid;
   residue_t sq_in;
   residue_t sq_out;

   msu i_msu (
      .clk           (clk),
      .reset_1d      (reset_1d),
      .ap_start      (ap_start),
      .start_xfer    (start_xfer),
      .ap_done       (ap_done),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tlast  (s_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tlast  (m_axis_tlast),
      .sq_start      (sq_start),
      .sq_stop       (sq_stop),
      .sq_in         (sq_in),
      .sq_valid      (sq_valid),
      .sq_out        (sq_out)
   );

   modsqr_engine i_modsqr_engine (
      .clk      (clk),
      .reset_1d (reset_1d),
      .sq_start (sq_start),
      .sq_stop  (sq_stop),
      .sq_in    (sq_in),
      .sq_valid (sq_valid),
      .sq_out   (sq_out)
   );

endmodule
